//--- src/busPkg.sv
`default_nettype none

package busPkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // wide enough for up to 16 cores
    localparam int OWNER_W = 4;

    typedef enum logic [2:0] {
        IDLE,
        IFETCH,
        WRITEBACK,
        SNOOP,
        CHECK,
        FLUSH,
        READ
    } busStateE;

    // matches the memory controller state output
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramStateE;

    typedef struct packed {
        logic iREN;
        logic dREN;
        logic dWEN;
        logic readX;
        logic [ADDR_W-1:0] iaddr;
        logic [ADDR_W-1:0] daddr;
        logic [DATA_W-1:0] dstore;
    } cacheReqT;

    typedef struct packed {
        logic ccDirty;
        logic [DATA_W-1:0] snoopData;
    } snoopRespT;

    typedef struct packed {
        logic iwait;
        logic dwait;
        logic [DATA_W-1:0] iload;
        logic [DATA_W-1:0] dload;
        logic ccwait;
        logic ccinv;
        logic [ADDR_W-1:0] ccsnoopaddr;
    } cacheRespT;

    typedef struct packed {
        busStateE state;
        logic [OWNER_W-1:0] owner;
        logic [ADDR_W-1:0] snoopAddr;
        logic readX;
    } busCtlT;

    typedef struct packed {
        logic dataReq;
        logic instrReq;
        logic isWrite;
        logic dirty;
    } portStatT;

    typedef struct packed {
        logic ramREN;
        logic ramWEN;
        logic [ADDR_W-1:0] ramaddr;
        logic [DATA_W-1:0] ramstore;
    } ramReqT;

endpackage

`default_nettype wire

//--- src/busSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module busSequencer #(
    parameter int CPUS = 2
) (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::portStatT [CPUS-1:0] portStat,
    // owner address and readX are taken from here when a transaction starts
    input  busPkg::cacheReqT [CPUS-1:0] cacheReq,
    input  logic ramDone,
    output busPkg::busCtlT busCtl
);
    import busPkg::*;

    busStateE state;
    busStateE stateNext;
    logic [OWNER_W-1:0] owner;
    logic [OWNER_W-1:0] ownerNext;
    logic [ADDR_W-1:0] snoopAddr;
    logic readX;
    logic anyDirty;

    // at most one peer can hold the block modified
    always_comb begin
        anyDirty = 1'b0;
        for (int i = 0; i < CPUS; i++) begin
            anyDirty = anyDirty | portStat[i].dirty;
        end
    end

    always_comb begin
        stateNext = state;
        ownerNext = owner;
        case (state)
            IDLE: begin
                // later loops override earlier ones and the lowest index wins inside each
                for (int i = CPUS - 1; i >= 0; i--) begin
                    if (portStat[i].instrReq) begin
                        stateNext = IFETCH;
                        ownerNext = OWNER_W'(i);
                    end
                end
                for (int i = CPUS - 1; i >= 0; i--) begin
                    if (portStat[i].dataReq && !portStat[i].isWrite) begin
                        stateNext = SNOOP;
                        ownerNext = OWNER_W'(i);
                    end
                end
                for (int i = CPUS - 1; i >= 0; i--) begin
                    if (portStat[i].dataReq && portStat[i].isWrite) begin
                        stateNext = WRITEBACK;
                        ownerNext = OWNER_W'(i);
                    end
                end
            end
            SNOOP: begin
                stateNext = CHECK;
            end
            CHECK: begin
                stateNext = anyDirty ? FLUSH : READ;
            end
            FLUSH: begin
                // dirty word goes to RAM before the requester reads
                if (ramDone) begin
                    stateNext = READ;
                end
            end
            IFETCH, WRITEBACK, READ: begin
                if (ramDone) begin
                    stateNext = IDLE;
                end
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            owner <= '0;
            readX <= 1'b0;
        end else begin
            state <= stateNext;
            owner <= ownerNext;
            if (state == IDLE) begin
                readX <= cacheReq[ownerNext].readX;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE) begin
            snoopAddr <= cacheReq[ownerNext].daddr;
        end
    end

    always_comb begin
        busCtl.state = state;
        busCtl.owner = owner;
        busCtl.snoopAddr = snoopAddr;
        busCtl.readX = readX;
    end

endmodule

`default_nettype wire

//--- src/cachePort.sv
`timescale 1ns/1ps
`default_nettype none

module cachePort #(
    parameter int CPUS = 2,
    parameter int myIndex = 0
) (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::cacheReqT req,
    input  busPkg::snoopRespT snoop,
    input  busPkg::busCtlT busCtl,
    input  logic [busPkg::DATA_W-1:0] ramload,
    input  logic ramDone,
    output busPkg::cacheRespT resp,
    output busPkg::portStatT stat,
    output busPkg::ramReqT ramReq
);
    import busPkg::*;

    logic isOwner;
    logic isPeer;
    logic snooped;
    logic finish;
    logic dirty;

    assign isOwner = int'(busCtl.owner) == myIndex;
    assign isPeer = !isOwner;
    assign snooped = isPeer && (busCtl.state inside {SNOOP, CHECK, FLUSH, READ});
    assign finish = isOwner && ramDone && (busCtl.state inside {IFETCH, WRITEBACK, READ});

    // peer's modified flag sampled at the end of SNOOP
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dirty <= 1'b0;
        end else if (busCtl.state == SNOOP) begin
            dirty <= isPeer && snoop.ccDirty;
        end else if (busCtl.state == IDLE) begin
            dirty <= 1'b0;
        end
    end

    always_comb begin
        resp.iwait = req.iREN && !(finish && busCtl.state == IFETCH);
        resp.dwait = (req.dREN || req.dWEN) && !(finish && busCtl.state != IFETCH);
        resp.iload = (isOwner && busCtl.state == IFETCH) ? ramload : '0;
        resp.dload = (isOwner && busCtl.state == READ) ? ramload : '0;
        resp.ccwait = snooped;
        resp.ccinv = isPeer && busCtl.readX && (busCtl.state == SNOOP);
        resp.ccsnoopaddr = snooped ? busCtl.snoopAddr : '0;
    end

    always_comb begin
        stat.dataReq = req.dREN || req.dWEN;
        stat.instrReq = req.iREN;
        stat.isWrite = req.dWEN;
        stat.dirty = dirty;
    end

    always_comb begin
        ramReq = '0;
        case (busCtl.state)
            IFETCH: begin
                ramReq.ramREN = isOwner;
                ramReq.ramaddr = isOwner ? req.iaddr : '0;
            end
            WRITEBACK: begin
                ramReq.ramWEN = isOwner;
                ramReq.ramaddr = isOwner ? req.daddr : '0;
                ramReq.ramstore = isOwner ? req.dstore : '0;
            end
            FLUSH: begin
                // the modified copy is written at the snooped address
                ramReq.ramWEN = dirty;
                ramReq.ramaddr = dirty ? busCtl.snoopAddr : '0;
                ramReq.ramstore = dirty ? snoop.snoopData : '0;
            end
            READ: begin
                ramReq.ramREN = isOwner;
                ramReq.ramaddr = isOwner ? req.daddr : '0;
            end
            default: begin
                ramReq = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/ramArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ramArbiter #(
    parameter int CPUS = 2
) (
    input  busPkg::ramReqT [CPUS-1:0] portReq,
    input  busPkg::ramStateE ramState,
    output busPkg::ramReqT ramReq,
    output logic ramDone
);
    import busPkg::*;

    ramReqT merged;
    logic active;

    // only one port drives a nonzero request
    always_comb begin
        merged = '0;
        for (int i = 0; i < CPUS; i++) begin
            merged = ramReqT'(merged | portReq[i]);
        end
    end

    assign active = merged.ramREN || merged.ramWEN;

    assign ramReq = merged;

    // one strobe per finished access
    assign ramDone = active && (ramState == ACCESS);

endmodule

`default_nettype wire

//--- src/busController.sv
`timescale 1ns/1ps
`default_nettype none

module busController #(
    parameter int CPUS = 2
) (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::cacheReqT [CPUS-1:0] cacheReq,
    input  busPkg::snoopRespT [CPUS-1:0] snoopResp,
    output busPkg::cacheRespT [CPUS-1:0] cacheResp,
    output busPkg::ramReqT ramReq,
    input  logic [busPkg::DATA_W-1:0] ramload,
    input  busPkg::ramStateE ramState
);
    import busPkg::*;

    busCtlT busCtl;
    portStatT [CPUS-1:0] portStat;
    ramReqT [CPUS-1:0] portRamReq;
    logic ramDone;

    busSequencer #(
        .CPUS(CPUS)
    ) uSequencer (
        .CLK(CLK),
        .nRST(nRST),
        .portStat(portStat),
        .cacheReq(cacheReq),
        .ramDone(ramDone),
        .busCtl(busCtl)
    );

    // one port per core
    for (genvar i = 0; i < CPUS; i++) begin : gPort
        cachePort #(
            .CPUS(CPUS),
            .myIndex(i)
        ) uPort (
            .CLK(CLK),
            .nRST(nRST),
            .req(cacheReq[i]),
            .snoop(snoopResp[i]),
            .busCtl(busCtl),
            .ramload(ramload),
            .ramDone(ramDone),
            .resp(cacheResp[i]),
            .stat(portStat[i]),
            .ramReq(portRamReq[i])
        );
    end

    ramArbiter #(
        .CPUS(CPUS)
    ) uRamArbiter (
        .portReq(portRamReq),
        .ramState(ramState),
        .ramReq(ramReq),
        .ramDone(ramDone)
    );

endmodule

`default_nettype wire

//--- verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // release just after an edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/busControllerAssertions.sv
`timescale 1ns/1ps
`default_nettype none

module busControllerAssertions #(
    parameter int CPUS = 2
) (
    input logic CLK,
    input logic nRST,
    input busPkg::cacheRespT [CPUS-1:0] cacheResp,
    input busPkg::ramReqT ramReq
);
    import busPkg::*;

    logic anyCoherence;

    always_comb begin
        anyCoherence = 1'b0;
        for (int i = 0; i < CPUS; i++) begin
            anyCoherence = anyCoherence | cacheResp[i].ccwait | cacheResp[i].ccinv;
        end
    end

    singleStrobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(ramReq.ramREN && ramReq.ramWEN))
        else $error("ramREN and ramWEN are high together");

    quietInReset: assert property (@(posedge CLK)
        !nRST |-> !(anyCoherence || ramReq.ramREN || ramReq.ramWEN))
        else $error("coherence or RAM strobe is high during reset");

    for (genvar i = 0; i < CPUS; i++) begin : gCore
        // a finishing owner is never snooped
        noSnoopOnFinish: assert property (@(posedge CLK) disable iff (!nRST)
            cacheResp[i].ccwait |-> !($fell(cacheResp[i].iwait) || $fell(cacheResp[i].dwait)))
            else $error("ccwait is high on core %0d while its wait goes low", i);

        invWithWait: assert property (@(posedge CLK) disable iff (!nRST)
            cacheResp[i].ccinv |-> cacheResp[i].ccwait)
            else $error("ccinv is high without ccwait on core %0d", i);
    end

endmodule

`default_nettype wire

//--- verification/busControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module busControllerTb;
    import busPkg::*;

    // six short tests with a few short RAM accesses each
    localparam int TIMEOUT_CYCLES = 2000;

    logic CLK;
    logic nRST;
    cacheReqT [1:0] cacheReq;
    snoopRespT [1:0] snoopResp;
    cacheRespT [1:0] cacheResp;
    ramReqT ramReq;
    logic [DATA_W-1:0] ramload;
    ramStateE ramState;
    logic [DATA_W-1:0] mem [0:255];
    int cycleCount = 0;
    logic sawCcwait;
    logic sawCcinv;

    tbClock uClock (
        .CLK(CLK),
        .nRST(nRST)
    );

    busController #(
        .CPUS(2)
    ) dut (
        .CLK(CLK),
        .nRST(nRST),
        .cacheReq(cacheReq),
        .snoopResp(snoopResp),
        .cacheResp(cacheResp),
        .ramReq(ramReq),
        .ramload(ramload),
        .ramState(ramState)
    );

    bind busController busControllerAssertions #(
        .CPUS(CPUS)
    ) uAssertions (
        .CLK(CLK),
        .nRST(nRST),
        .cacheResp(cacheResp),
        .ramReq(ramReq)
    );

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h0001_9E37) ^ 32'hC3A5_5A3C;
    endfunction

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // random BUSY stretch before one ACCESS cycle
    initial begin : ramModel
        int busyLeft;
        logic started;
        busyLeft = 0;
        started = 1'b0;
        ramState = FREE;
        ramload = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillWord(32'(i) << 2);
        end
        void'($urandom(32'h29a5d9f2));
        forever begin
            @(posedge CLK);
            #1;
            if (!nRST || !(ramReq.ramREN || ramReq.ramWEN)) begin
                ramState = FREE;
                ramload = '0;
                started = 1'b0;
            end else begin
                if (!started) begin
                    busyLeft = $urandom_range(3, 0);
                    started = 1'b1;
                end
                if (busyLeft > 0) begin
                    ramState = BUSY;
                    ramload = '0;
                    busyLeft--;
                end else begin
                    // access ends at the next edge
                    ramState = ACCESS;
                    started = 1'b0;
                    if (ramReq.ramWEN) begin
                        mem[ramReq.ramaddr[9:2]] = ramReq.ramstore;
                    end
                    ramload = ramReq.ramREN ? mem[ramReq.ramaddr[9:2]] : '0;
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    // waits for the core's dwait to drop, watching the other core's snoop lines
    task automatic finishData(input string testName, input int core,
                              output logic [31:0] load);
        int other;
        logic done;
        other = 1 - core;
        sawCcwait = 1'b0;
        sawCcinv = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (cacheResp[other].ccwait) begin
                sawCcwait = 1'b1;
                compareValue(testName, cacheReq[core].daddr, cacheResp[other].ccsnoopaddr);
            end
            if (cacheResp[other].ccinv) begin
                sawCcinv = 1'b1;
                compareValue(testName, 32'd1, 32'(cacheResp[other].ccwait));
            end
            load = cacheResp[core].dload;
            done = !cacheResp[core].dwait;
            @(posedge CLK);
            #1;
        end
        cacheReq[core].dREN = 1'b0;
        cacheReq[core].dWEN = 1'b0;
        cacheReq[core].readX = 1'b0;
    endtask

    task automatic resetState();
        repeat (2) begin
            @(negedge CLK);
            compareValue("reset state", 32'd0, {22'd0,
                cacheResp[0].iwait, cacheResp[0].dwait, cacheResp[0].ccwait, cacheResp[0].ccinv,
                cacheResp[1].iwait, cacheResp[1].dwait, cacheResp[1].ccwait, cacheResp[1].ccinv,
                ramReq.ramREN, ramReq.ramWEN});
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic instrFetch();
        logic [1:0] done;
        done = 2'b00;
        cacheReq[0].iREN = 1'b1;
        cacheReq[0].iaddr = 32'h0000_0040;
        cacheReq[1].iREN = 1'b1;
        cacheReq[1].iaddr = 32'h0000_0104;
        while (done != 2'b11) begin
            @(negedge CLK);
            for (int c = 0; c < 2; c++) begin
                if (!done[c] && !cacheResp[c].iwait) begin
                    compareValue("instruction fetch", fillWord(cacheReq[c].iaddr),
                                 cacheResp[c].iload);
                    // lower index wins the tie
                    if (c == 1) begin
                        compareValue("instruction fetch", 32'd1, 32'(done[0]));
                    end
                    done[c] = 1'b1;
                end
            end
            @(posedge CLK);
            #1;
            for (int c = 0; c < 2; c++) begin
                if (done[c]) begin
                    cacheReq[c].iREN = 1'b0;
                end
            end
        end
    endtask

    task automatic cleanRead();
        logic [31:0] load;
        cacheReq[0].dREN = 1'b1;
        cacheReq[0].readX = 1'b0;
        cacheReq[0].daddr = 32'h0000_0208;
        snoopResp[1] = '0;
        finishData("clean read miss", 0, load);
        compareValue("clean read miss", 32'd1, 32'(sawCcwait));
        compareValue("clean read miss", 32'd0, 32'(sawCcinv));
        compareValue("clean read miss", fillWord(32'h0000_0208), load);
    endtask

    task automatic dirtyRead();
        logic [31:0] load;
        logic [31:0] addr;
        addr = 32'h0000_030C;
        cacheReq[1].dREN = 1'b1;
        cacheReq[1].daddr = addr;
        snoopResp[0].ccDirty = 1'b1;
        snoopResp[0].snoopData = 32'h5EED_1234;
        finishData("dirty-peer read", 1, load);
        compareValue("dirty-peer read", 32'h5EED_1234, mem[addr[9:2]]);
        compareValue("dirty-peer read", 32'h5EED_1234, load);
        snoopResp[0] = '0;
    endtask

    task automatic readXRead();
        logic [31:0] load;
        cacheReq[0].dREN = 1'b1;
        cacheReq[0].readX = 1'b1;
        cacheReq[0].daddr = 32'h0000_03F0;
        finishData("read for ownership", 0, load);
        compareValue("read for ownership", 32'd1, 32'(sawCcinv));
        compareValue("read for ownership", fillWord(32'h0000_03F0), load);
    endtask

    task automatic writeBack();
        logic [31:0] load;
        cacheReq[1].dWEN = 1'b1;
        cacheReq[1].daddr = 32'h0000_00A4;
        cacheReq[1].dstore = 32'hD00D_F00D;
        finishData("write-back", 1, load);
        compareValue("write-back", 32'd0, 32'(sawCcwait));
        compareValue("write-back", 32'hD00D_F00D, mem[8'h00A4 >> 2]);
    endtask

    initial begin
        cacheReq = '0;
        snoopResp = '0;
        wait (nRST === 1'b1);
        resetState();
        instrFetch();
        cleanRead();
        dirtyRead();
        readXRead();
        writeBack();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- busController.f
src/busPkg.sv
src/busSequencer.sv
src/cachePort.sv
src/ramArbiter.sv
src/busController.sv
verification/tbClock.sv
verification/busControllerAssertions.sv
verification/busControllerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= busControllerTb
FILELIST ?= busController.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
